/* code_angle_pkg.sv */
`default_nettype none

package code_angle_pkg;

    // --------------------------------------------------
    // widths
    // --------------------------------------------------
    // angle in hundredths of a degree
    localparam int ANGLE_W = 16;
    // tooth index since the zero mark
    localparam int IDX_W = 8;
    // tooth period in clocks
    localparam int PER_W = 16;
    // clocks since the zero mark
    localparam int TIME_W = 24;
    // divider dividend and quotient
    localparam int DIVD_W = 32;

    // hundredths of a degree in one turn
    localparam int FULL_TURN_CDEG = 36000;

    // angle covered by one tooth, the gap counts as one tooth here
    function automatic int step_cdeg(input int tooth_num);
        return FULL_TURN_CDEG / tooth_num;
    endfunction

    // --------------------------------------------------
    // block interfaces
    // --------------------------------------------------
    // tooth tracker state, held between edges
    typedef struct packed {
        logic [IDX_W-1:0] index;
        logic [PER_W-1:0] period;
        logic             seen;
    } tooth_info_t;

    // firing stamp, valid for one clock
    typedef struct packed {
        logic [TIME_W-1:0] cycle_time;
        logic              valid;
    } sync_stamp_t;

    // finished angle and the tooth it was taken on
    typedef struct packed {
        logic [ANGLE_W-1:0] angle;
        logic [IDX_W-1:0]   index;
    } angle_result_t;

endpackage

`default_nettype wire

/* tooth_tracker.sv */
`timescale 1ns/1ps
`default_nettype none

module tooth_tracker import code_angle_pkg::*; #(
    parameter int TOOTH_NUM = 100
) (
    input  wire         i_clk,
    input  wire         i_rst_n,
    input  wire         i_opto_rise,
    input  wire         i_zero_sign,
    output tooth_info_t o_tooth
);

    logic             w_edge;
    logic [PER_W-1:0] r_cnt;
    logic [PER_W-1:0] r_period;
    logic [IDX_W-1:0] r_index;
    logic             r_started;
    logic             r_seen;

    // the zero mark ends a period just like a tooth edge
    assign w_edge = i_opto_rise | i_zero_sign;

    // --------------------------------------------------
    // period measurement
    // --------------------------------------------------
    // clocks since last edge, holds at max on a stalled disk
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_cnt <= '0;
        end else if (w_edge) begin
            r_cnt <= PER_W'(1);
        end else if (r_cnt != '1) begin
            r_cnt <= r_cnt + 1'b1;
        end
    end

    // first edge only starts the count, the second one closes a period
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_started <= 1'b0;
            r_seen    <= 1'b0;
            r_period  <= '0;
        end else if (w_edge) begin
            r_started <= 1'b1;
            if (r_started) begin
                r_seen   <= 1'b1;
                r_period <= r_cnt;
            end
        end
    end

    // --------------------------------------------------
    // tooth index
    // --------------------------------------------------
    // zero mark wins over a coincident tooth edge
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_index <= '0;
        end else if (i_zero_sign) begin
            r_index <= '0;
        end else if (i_opto_rise) begin
            if (r_index == IDX_W'(TOOTH_NUM - 1)) begin
                r_index <= '0;
            end else begin
                r_index <= r_index + 1'b1;
            end
        end
    end

    assign o_tooth = '{index: r_index, period: r_period, seen: r_seen};

endmodule

`default_nettype wire

/* sync_capture.sv */
`timescale 1ns/1ps
`default_nettype none

module sync_capture import code_angle_pkg::*; (
    input  wire         i_clk,
    input  wire         i_rst_n,
    input  wire         i_zero_sign,
    input  wire         i_angle_sync,
    input  wire         i_enable,
    input  wire         i_busy,
    output sync_stamp_t o_stamp,
    output logic        o_drop
);

    logic [TIME_W-1:0] r_time;
    logic [TIME_W-1:0] r_stamp_time;
    logic              r_valid;
    logic              r_drop;
    logic              w_fire;
    logic              w_busy;

    // --------------------------------------------------
    // time since zero
    // --------------------------------------------------
    // saturates so a missing zero mark cannot wrap back to 0
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_time <= '0;
        end else if (i_zero_sign) begin
            r_time <= '0;
        end else if (r_time != '1) begin
            r_time <= r_time + 1'b1;
        end
    end

    // --------------------------------------------------
    // firing capture
    // --------------------------------------------------
    assign w_fire = i_angle_sync & i_enable;
    // a stamp still on its way to the calculator counts as busy too
    assign w_busy = i_busy | r_valid;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_valid <= 1'b0;
            r_drop  <= 1'b0;
        end else begin
            r_valid <= w_fire & ~w_busy;
            r_drop  <= w_fire & w_busy;
        end
    end

    // time since zero held for the calculator
    always_ff @(posedge i_clk) begin
        if (w_fire && !w_busy) begin
            r_stamp_time <= r_time;
        end
    end

    assign o_stamp = '{cycle_time: r_stamp_time, valid: r_valid};
    assign o_drop  = r_drop;

endmodule

`default_nettype wire

/* serial_divider.sv */
`timescale 1ns/1ps
`default_nettype none

module serial_divider import code_angle_pkg::*; (
    input  wire                i_clk,
    input  wire                i_rst_n,
    input  wire                i_start,
    input  wire  [DIVD_W-1:0]  i_dividend,
    input  wire  [PER_W-1:0]   i_divisor,
    output logic [DIVD_W-1:0]  o_quotient,
    output logic               o_done
);

    localparam int CNT_W = $clog2(DIVD_W);

    logic [DIVD_W-1:0] r_quo;
    logic [PER_W-1:0]  r_rem;
    logic [PER_W-1:0]  r_dvs;
    logic [CNT_W-1:0]  r_cnt;
    logic              r_run;
    logic              r_done;

    logic [DIVD_W-1:0] w_src;
    logic [PER_W-1:0]  w_rem_in;
    logic [PER_W-1:0]  w_dvs;
    logic [PER_W:0]    w_trial;
    logic              w_fit;
    logic [PER_W-1:0]  w_rem_out;

    // --------------------------------------------------
    // one restoring step
    // --------------------------------------------------
    // start cycle already does step one on the fresh operands
    assign w_src    = i_start ? i_dividend : r_quo;
    assign w_rem_in = i_start ? '0 : r_rem;
    assign w_dvs    = i_start ? i_divisor : r_dvs;

    // shift in next dividend bit and try the subtract
    assign w_trial = {w_rem_in, w_src[DIVD_W-1]} - {1'b0, w_dvs};
    // no borrow means it fits, zero divisor always fits
    assign w_fit   = ~w_trial[PER_W] | (w_dvs == '0);
    assign w_rem_out = w_fit ? w_trial[PER_W-1:0]
                             : {w_rem_in[PER_W-2:0], w_src[DIVD_W-1]};

    // dividend shifts out the top while quotient bits fill the bottom
    always_ff @(posedge i_clk) begin
        if (i_start || r_run) begin
            r_quo <= {w_src[DIVD_W-2:0], w_fit};
            r_rem <= w_rem_out;
        end
        if (i_start) begin
            r_dvs <= i_divisor;
        end
    end

    // --------------------------------------------------
    // step counter
    // --------------------------------------------------
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_run  <= 1'b0;
            r_cnt  <= '0;
            r_done <= 1'b0;
        end else begin
            r_done <= r_run && (r_cnt == CNT_W'(DIVD_W - 1));
            if (i_start) begin
                r_run <= 1'b1;
                r_cnt <= CNT_W'(1);
            end else if (r_run) begin
                r_cnt <= r_cnt + 1'b1;
                // last of the 32 steps
                if (r_cnt == CNT_W'(DIVD_W - 1)) begin
                    r_run <= 1'b0;
                end
            end
        end
    end

    assign o_quotient = r_quo;
    assign o_done     = r_done;

endmodule

`default_nettype wire

/* angle_calc.sv */
`timescale 1ns/1ps
`default_nettype none

module angle_calc import code_angle_pkg::*; #(
    parameter int TOOTH_NUM = 100
) (
    input  wire           i_clk,
    input  wire           i_rst_n,
    input  tooth_info_t   i_tooth,
    input  sync_stamp_t   i_stamp,
    output angle_result_t o_result,
    output logic          o_result_valid,
    output logic          o_busy
);

    localparam int STEP      = step_cdeg(TOOTH_NUM);
    localparam int ANGLE_MAX = FULL_TURN_CDEG - 1;
    // wide enough for a doubled step of one tooth per turn
    localparam int MUL_W     = TIME_W + 18;

    localparam logic [2:0] S_IDLE = 3'd0;
    localparam logic [2:0] S_OPER = 3'd1;
    localparam logic [2:0] S_MULT = 3'd2;
    localparam logic [2:0] S_DIV  = 3'd3;
    localparam logic [2:0] S_DONE = 3'd4;

    logic [2:0]        r_state;
    logic [TIME_W-1:0] r_time;
    logic              r_double;
    logic [IDX_W-1:0]  r_index;
    logic [PER_W-1:0]  r_divisor;
    logic [DIVD_W-1:0] r_prod;
    angle_result_t     r_result;
    logic              r_valid;

    logic [17:0]       w_step;
    logic [MUL_W-1:0]  w_prod_full;
    logic [DIVD_W-1:0] w_prod_sat;
    logic [DIVD_W-1:0] w_quo;
    logic              w_div_done;
    logic [ANGLE_W-1:0] w_angle;

    // --------------------------------------------------
    // numerator
    // --------------------------------------------------
    // index 0 means the last period was the double-length gap
    assign w_step      = r_double ? 18'(2 * STEP) : 18'(STEP);
    assign w_prod_full = MUL_W'(r_time) * MUL_W'(w_step);
    // a saturated time gives a huge dividend, clamped later anyway
    assign w_prod_sat  = (|w_prod_full[MUL_W-1:DIVD_W]) ? '1 : w_prod_full[DIVD_W-1:0];

    // stale period on a slowing disk can push past one turn
    assign w_angle = (w_quo > DIVD_W'(ANGLE_MAX)) ? ANGLE_W'(ANGLE_MAX)
                                                   : w_quo[ANGLE_W-1:0];

    // --------------------------------------------------
    // sequencer
    // --------------------------------------------------
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_state <= S_IDLE;
            r_valid <= 1'b0;
        end else begin
            r_valid <= 1'b0;
            case (r_state)
                // no period measured yet, nothing to divide by
                S_IDLE: if (i_stamp.valid && i_tooth.seen) r_state <= S_OPER;
                S_OPER: r_state <= S_MULT;
                S_MULT: r_state <= S_DIV;
                S_DIV: begin
                    if (w_div_done) begin
                        r_valid <= 1'b1;
                        r_state <= S_DONE;
                    end
                end
                default: r_state <= S_IDLE;
            endcase
        end
    end

    // operand latch, product and result registers
    always_ff @(posedge i_clk) begin
        if (r_state == S_IDLE) begin
            r_time    <= i_stamp.cycle_time;
            r_double  <= (i_tooth.index == '0);
            r_index   <= i_tooth.index;
            r_divisor <= i_tooth.period;
        end
        if (r_state == S_OPER) begin
            r_prod <= w_prod_sat;
        end
        if (r_state == S_DIV && w_div_done) begin
            r_result <= '{angle: w_angle, index: r_index};
        end
    end

    serial_divider u_serial_divider (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_start    (r_state == S_MULT),
        .i_dividend (r_prod),
        .i_divisor  (r_divisor),
        .o_quotient (w_quo),
        .o_done     (w_div_done)
    );

    assign o_result       = r_result;
    assign o_result_valid = r_valid;
    assign o_busy         = (r_state != S_IDLE);

endmodule

`default_nettype wire

/* wb_angle_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module wb_angle_regs import code_angle_pkg::*; (
    input  wire               i_clk,
    input  wire               i_rst_n,
    input  wire               i_wb_cyc,
    input  wire               i_wb_stb,
    input  wire               i_wb_we,
    input  wire  [1:0]        i_wb_adr,
    input  wire  [31:0]       i_wb_dat,
    output logic [31:0]       o_wb_dat,
    output logic              o_wb_ack,
    input  angle_result_t     i_result,
    input  wire               i_result_valid,
    input  wire               i_drop,
    input  wire  [PER_W-1:0]  i_period,
    output logic              o_enable
);

    localparam logic [1:0] ADR_CTRL   = 2'd0;
    localparam logic [1:0] ADR_RESULT = 2'd1;
    localparam logic [1:0] ADR_STATUS = 2'd2;

    logic          r_ack;
    logic          r_hold;
    logic          r_enable;
    logic [7:0]    r_drop_cnt;
    angle_result_t r_result;
    logic          w_req;
    logic          w_wr;
    logic          w_clr;

    // --------------------------------------------------
    // bus handshake
    // --------------------------------------------------
    // hold remembers the strobe so one access gets one ack
    assign w_req = i_wb_cyc & i_wb_stb & ~r_hold;
    // write data is taken while ack is out
    assign w_wr  = r_ack & i_wb_cyc & i_wb_stb & i_wb_we;
    // clear bit is a strobe, never stored
    assign w_clr = w_wr & (i_wb_adr == ADR_CTRL) & i_wb_dat[1];

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_ack  <= 1'b0;
            r_hold <= 1'b0;
        end else begin
            r_ack  <= w_req;
            r_hold <= i_wb_cyc & i_wb_stb;
        end
    end

    // --------------------------------------------------
    // registers
    // --------------------------------------------------
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_enable <= 1'b0;
            r_result <= '0;
        end else begin
            if (w_wr && i_wb_adr == ADR_CTRL) begin
                r_enable <= i_wb_dat[0];
            end
            // each new result overwrites the last one
            if (i_result_valid) begin
                r_result <= i_result;
            end
        end
    end

    // clear beats a drop in the same cycle, count sticks at 255
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_drop_cnt <= '0;
        end else if (w_clr) begin
            r_drop_cnt <= '0;
        end else if (i_drop && r_drop_cnt != 8'hff) begin
            r_drop_cnt <= r_drop_cnt + 1'b1;
        end
    end

    // read mux, sampled by the host while ack is high
    always_comb begin
        case (i_wb_adr)
            ADR_CTRL:   o_wb_dat = {31'd0, r_enable};
            ADR_RESULT: o_wb_dat = {8'd0, r_result.index, r_result.angle};
            ADR_STATUS: o_wb_dat = {i_period, 8'd0, r_drop_cnt};
            default:    o_wb_dat = '0;
        endcase
    end

    assign o_wb_ack = r_ack;
    assign o_enable = r_enable;

endmodule

`default_nettype wire

/* code_angle_top.sv */
`timescale 1ns/1ps
`default_nettype none

module code_angle_top import code_angle_pkg::*; #(
    parameter int TOOTH_NUM = 100
) (
    input  wire                i_clk,
    input  wire                i_rst_n,
    input  wire                i_opto_rise,
    input  wire                i_zero_sign,
    input  wire                i_angle_sync,
    input  wire                i_wb_cyc,
    input  wire                i_wb_stb,
    input  wire                i_wb_we,
    input  wire  [1:0]         i_wb_adr,
    input  wire  [31:0]        i_wb_dat,
    output logic [31:0]        o_wb_dat,
    output logic               o_wb_ack,
    output logic [ANGLE_W-1:0] o_angle,
    output logic               o_angle_valid
);

    tooth_info_t   w_tooth;
    sync_stamp_t   w_stamp;
    angle_result_t w_result;
    logic          w_result_valid;
    logic          w_busy;
    logic          w_enable;
    logic          w_drop;

    // --------------------------------------------------
    // front ends
    // --------------------------------------------------
    tooth_tracker #(
        .TOOTH_NUM (TOOTH_NUM)
    ) u_tooth_tracker (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_opto_rise (i_opto_rise),
        .i_zero_sign (i_zero_sign),
        .o_tooth     (w_tooth)
    );

    sync_capture u_sync_capture (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_zero_sign  (i_zero_sign),
        .i_angle_sync (i_angle_sync),
        .i_enable     (w_enable),
        .i_busy       (w_busy),
        .o_stamp      (w_stamp),
        .o_drop       (w_drop)
    );

    // --------------------------------------------------
    // calculator and host registers
    // --------------------------------------------------
    angle_calc #(
        .TOOTH_NUM (TOOTH_NUM)
    ) u_angle_calc (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_tooth        (w_tooth),
        .i_stamp        (w_stamp),
        .o_result       (w_result),
        .o_result_valid (w_result_valid),
        .o_busy         (w_busy)
    );

    wb_angle_regs u_wb_angle_regs (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_wb_cyc       (i_wb_cyc),
        .i_wb_stb       (i_wb_stb),
        .i_wb_we        (i_wb_we),
        .i_wb_adr       (i_wb_adr),
        .i_wb_dat       (i_wb_dat),
        .o_wb_dat       (o_wb_dat),
        .o_wb_ack       (o_wb_ack),
        .i_result       (w_result),
        .i_result_valid (w_result_valid),
        .i_drop         (w_drop),
        .i_period       (w_tooth.period),
        .o_enable       (w_enable)
    );

    assign o_angle       = w_result.angle;
    assign o_angle_valid = w_result_valid;

endmodule

`default_nettype wire

/* code_angle_top_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module code_angle_top_assert (
    input wire        i_clk,
    input wire        i_rst_n,
    input wire        i_wb_cyc,
    input wire        i_wb_stb,
    input wire        i_wb_ack,
    input wire        i_angle_valid,
    input wire [15:0] i_angle,
    input wire        i_stamp_valid,
    input wire        i_tooth_seen
);

    // cycles since the previous result pulse, sticks at its max
    logic [7:0] r_since_valid;
    // number of failed assertions so far
    int fail_count = 0;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_since_valid <= 8'hff;
        end else if (i_angle_valid) begin
            r_since_valid <= 8'd1;
        end else if (r_since_valid != 8'hff) begin
            r_since_valid <= r_since_valid + 8'd1;
        end
    end

    // --------------------------------------------------
    // bus handshake
    // --------------------------------------------------
    ack_one_cycle: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_wb_ack |=> !i_wb_ack)
        else begin
            $error("ack held for more than one cycle");
            fail_count++;
        end

    ack_after_req: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_wb_ack |-> $past(i_wb_cyc && i_wb_stb))
        else begin
            $error("ack without a cyc and stb request");
            fail_count++;
        end

    // --------------------------------------------------
    // result rules
    // --------------------------------------------------
    valid_spacing: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_angle_valid |-> (r_since_valid >= 8'd37))
        else begin
            $error("results closer than 37 cycles");
            fail_count++;
        end

    angle_range: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_angle_valid |-> (i_angle <= 16'd35999))
        else begin
            $error("angle above 35999");
            fail_count++;
        end

    // stamp is one cycle after the firing, so 35 more gives 36 in total
    latency_fixed: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $past(i_stamp_valid && i_tooth_seen, 35) |-> i_angle_valid)
        else begin
            $error("no result 36 cycles after an accepted firing");
            fail_count++;
        end

    latency_only: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_angle_valid |-> $past(i_stamp_valid && i_tooth_seen, 35))
        else begin
            $error("result without an accepted firing 36 cycles before");
            fail_count++;
        end

endmodule

bind code_angle_top code_angle_top_assert u_code_angle_top_assert (
    .i_clk         (i_clk),
    .i_rst_n       (i_rst_n),
    .i_wb_cyc      (i_wb_cyc),
    .i_wb_stb      (i_wb_stb),
    .i_wb_ack      (o_wb_ack),
    .i_angle_valid (o_angle_valid),
    .i_angle       (o_angle),
    .i_stamp_valid (w_stamp.valid),
    .i_tooth_seen  (w_tooth.seen)
);

`default_nettype wire

/* tb_code_angle_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_code_angle_top;

    localparam int TEETH = 100;
    localparam int TOOTH_CLK = 50;
    localparam int TURN_CLK = TEETH * TOOTH_CLK;

    logic i_clk, i_rst_n, i_opto_rise, i_zero_sign, i_angle_sync;
    logic i_wb_cyc, i_wb_stb, i_wb_we;
    logic [1:0] i_wb_adr;
    logic [31:0] i_wb_dat, o_wb_dat;
    logic o_wb_ack, o_angle_valid;
    logic [15:0] o_angle;

    int seed = 32'h39f9;
    int errors = 0, tests = 0, failed = 0, err_start;
    // encoder position in the turn, zero mark at 0
    // starts one clock short of the mark so the first zero mark is driven
    int enc_pos = TURN_CLK - 1;
    bit enc_run = 0;
    // reference model state
    int cyc = 0, zero_cyc = 0, last_edge = 0, m_index = 0, m_period = 0;
    bit m_started = 0;
    int f_time, f_index, f_period;
    logic [31:0] rd;

    code_angle_top #(.TOOTH_NUM(TEETH)) u_code_angle_top (.*);

    always #20 i_clk = ~i_clk;

    // encoder drive on the falling edge, gap is two tooth slots long
    always @(negedge i_clk) begin
        i_zero_sign = enc_run && (enc_pos == 0);
        i_opto_rise = enc_run && (enc_pos % TOOTH_CLK == 0) && (enc_pos >= TOOTH_CLK)
                      && (enc_pos <= TURN_CLK - 2 * TOOTH_CLK);
    end

    // --------------------------------------------------
    // reference model, follows the driven inputs
    // --------------------------------------------------
    always @(posedge i_clk) begin
        cyc++;
        if (enc_run) enc_pos = (enc_pos + 1) % TURN_CLK;
        if (i_zero_sign || i_opto_rise) begin
            if (m_started) m_period = cyc - last_edge;
            m_started = 1;
            last_edge = cyc;
        end
        if (i_zero_sign) m_index = 0;
        else if (i_opto_rise) m_index = (m_index == TEETH - 1) ? 0 : m_index + 1;
        // time counter is read before this edge clears it
        if (i_angle_sync) begin
            f_time = cyc - zero_cyc - 1;
            f_index = m_index;
            f_period = m_period;
        end
        if (i_zero_sign) zero_cyc = cyc;
    end

    // interpolation rule with the gap tooth doubled and the clamp
    function automatic int expect_angle(int t, int idx, int per);
        longint num;
        longint q;
        num = longint'(t) * (36000 / TEETH) * ((idx == 0) ? 2 : 1);
        q = num / per;
        if (q > 35999) q = 35999;
        return int'(q);
    endfunction

    task automatic check_val(input string name, input int exp, input int act);
        if (exp != act) begin
            $display("Error at %0d ns: %s expected %0d, got %0d", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic wait_pos(input int target);
        int n;
        n = 0;
        while (enc_pos != target && n < 3 * TURN_CLK) begin
            @(negedge i_clk);
            n++;
        end
        if (enc_pos != target) begin
            $display("Timeout: encoder never reached position %0d", target);
            errors++;
        end
    endtask

    task automatic wb_access(input bit we, input logic [1:0] adr, input logic [31:0] wdat,
                             output logic [31:0] rdat);
        int n;
        i_wb_we = we;
        i_wb_adr = adr;
        i_wb_dat = wdat;
        i_wb_cyc = 1;
        i_wb_stb = 1;
        n = 0;
        do begin
            @(negedge i_clk);
            n++;
        end while (!o_wb_ack && n < 20);
        if (!o_wb_ack) begin
            $display("Timeout: no Wishbone ack at address %0d", adr);
            errors++;
        end
        rdat = o_wb_dat;
        // keep the request through the ack cycle so the write lands
        @(negedge i_clk);
        i_wb_cyc = 0;
        i_wb_stb = 0;
        i_wb_we = 0;
        // one idle cycle so the slave sees the strobe drop
        @(negedge i_clk);
    endtask

    task automatic fire();
        i_angle_sync = 1;
        @(negedge i_clk);
        i_angle_sync = 0;
    endtask

    // fire at a position and compare the result with the model
    task automatic fire_and_check(input int pos);
        int n, exp;
        wait_pos(pos);
        fire();
        exp = expect_angle(f_time, f_index, f_period);
        n = 0;
        while (!o_angle_valid && n < 60) begin
            @(negedge i_clk);
            n++;
        end
        if (!o_angle_valid) begin
            $display("Timeout: no result after a firing at position %0d", pos);
            errors++;
        end else begin
            check_val("o_angle", exp, o_angle);
            check_val("tooth index", f_index, u_code_angle_top.w_result.index);
        end
        @(negedge i_clk);
    endtask

    task automatic test_begin();
        err_start = errors;
        tests++;
    endtask

    task automatic test_end(input string name);
        if (errors != err_start) failed++;
        $display("test %0d %s: %s", tests, name, (errors == err_start) ? "ok" : "failed");
    endtask

    // --------------------------------------------------
    // test sequence
    // --------------------------------------------------
    initial begin
        int n, p;
        i_clk = 0;
        i_rst_n = 0;
        i_opto_rise = 0;
        i_zero_sign = 0;
        i_angle_sync = 0;
        i_wb_cyc = 0;
        i_wb_stb = 0;
        i_wb_we = 0;
        i_wb_adr = 0;
        i_wb_dat = 0;
        repeat (3) @(posedge i_clk);
        @(negedge i_clk);
        i_rst_n = 1;
        enc_run = 1;
        wait_pos(200);

        test_begin();
        for (int k = 0; k < 2; k++) begin
            fire();
            n = 0;
            while (n < 50) begin
                if (o_angle_valid) begin
                    $display("Error at %0d ns: o_angle_valid high while disabled", $time);
                    errors++;
                end
                @(negedge i_clk);
                n++;
            end
        end
        wb_access(0, 2'd0, 0, rd);
        check_val("CTRL", 0, rd);
        test_end("disabled");

        test_begin();
        wb_access(1, 2'd0, 32'h1, rd);
        for (int k = 0; k < 4; k++) begin
            p = 100 + (($random(seed) & 32'hffff) % (TURN_CLK - 200));
            fire_and_check(p);
        end
        test_end("steady teeth");

        test_begin();
        p = 1 + (($random(seed) & 32'hffff) % (TOOTH_CLK - 2));
        fire_and_check(p);
        test_end("gap tooth");

        test_begin();
        wait_pos(1500);
        fire();
        repeat (9) @(negedge i_clk);
        fire();
        n = 0;
        while (n < 80) begin
            @(negedge i_clk);
            n++;
        end
        wb_access(0, 2'd2, 0, rd);
        check_val("drop count", 1, rd[7:0]);
        wb_access(1, 2'd0, 32'h3, rd);
        wb_access(0, 2'd2, 0, rd);
        check_val("drop count after clear", 0, rd[7:0]);
        test_end("drop and clear");

        test_begin();
        fire_and_check(2222);
        wb_access(0, 2'd1, 0, rd);
        check_val("RESULT angle", expect_angle(f_time, f_index, f_period), rd[15:0]);
        check_val("RESULT index", f_index, rd[23:16]);
        wb_access(0, 2'd2, 0, rd);
        check_val("STATUS period", TOOTH_CLK, rd[31:16]);
        test_end("register read");

        test_begin();
        // stop the disk so the zero mark stays away
        wait_pos(4010);
        enc_run = 0;
        repeat (1300) @(negedge i_clk);
        fire_and_check(4010);
        check_val("clamped o_angle", 35999, o_angle);
        enc_run = 1;
        test_end("clamp");

        errors += u_code_angle_top.u_code_angle_top_assert.fail_count;
        $display("tests: %0d, failed: %0d, errors: %0d, assertion failures: %0d",
                 tests, failed, errors, u_code_angle_top.u_code_angle_top_assert.fail_count);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
code_angle_pkg.sv
tooth_tracker.sv
sync_capture.sv
serial_divider.sv
angle_calc.sv
wb_angle_regs.sv
code_angle_top.sv
code_angle_top_assert.sv
tb_code_angle_top.sv

/* run_sim.sh */
#!/bin/sh
# build and run with Verilator, the log decides the verdict
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f vlog.f --top-module tb_code_angle_top \
    -o sim_tb > build.log 2>&1 \
    && ./obj_dir/sim_tb > sim.log 2>&1 \
    || { echo "build or simulation failed"; exit 1; }
grep -q "STATUS: FAIL" sim.log && { echo "simulation failed"; exit 1; } \
    || { grep -q "STATUS: PASS" sim.log && echo "simulation passed" || exit 1; }
